// ==== verilog/isaPkg.sv ====
`default_nettype none

package isaPkg;

    parameter int instrWidth  = 16;
    parameter int regIdxWidth = 4;

    // condition field, instruction bits 15:13
    typedef enum logic [2:0] {
        condAlways    = 3'd0,
        condCarry     = 3'd1,
        condNoCarry   = 3'd2,
        condZero      = 3'd3,
        condNotZero   = 3'd4,
        condNeg       = 3'd5,
        condNotNeg    = 3'd6,
        condAlwaysAlt = 3'd7   // second encoding of always
    } condCode_e;

    typedef enum logic [3:0] {
        opAluImm,
        opAluReg,
        opJmp,
        opCall,
        opRet,
        opPush,
        opPop,
        opSetSr,
        opClrSr,
        opHalt,
        opNop
    } opClass_e;

    typedef struct packed {
        opClass_e                opClass;
        logic [regIdxWidth-1:0]  dstIdx;     // bits 15:12
        logic [regIdxWidth-1:0]  srcIdx;     // bits 11:8
        logic [3:0]              aluMode;
        logic [3:0]              mask;       // status mask, bits 11:8
        logic                    condMet;
        logic                    setsFlags;
    } decodedInstr_t;

endpackage

`default_nettype wire

// ==== verilog/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    // only the modes the sequencer picks itself are named
    typedef enum logic [3:0] {
        passB = 4'd0,
        andOp = 4'd1,
        orOp  = 4'd2,
        passA = 4'd13
    } aluMode_e;

    typedef enum logic [1:0] {aluOut = 2'd0, memOut = 2'd2} rfSrc_e;

    typedef enum logic [1:0] {regB = 2'd0, mask4 = 2'd1, imm8 = 2'd2} aluSrcB_e;

    typedef enum logic [2:0] {
        pcNextHi   = 3'd0,
        pcNextLo   = 3'd1,
        dataAluOut = 3'd2,
        pcHi       = 3'd3,
        pcLo       = 3'd4
    } dMemData_e;

    typedef enum logic [1:0] {regPair = 2'd0, regPairPlusOne = 2'd2} dMemAddr_e;

    typedef enum logic [1:0] {
        aluFlags   = 2'd0,
        srAluOut   = 2'd1,
        srMemOut   = 2'd2,
        disableIrq = 2'd3   // keep flags, clear interrupt enable
    } srSrc_e;

    typedef enum logic [2:0] {
        pcPlusOne  = 3'd0,
        pcOut      = 3'd1,
        irqVector  = 3'd2,
        iMemOut    = 3'd3,
        returnAddr = 3'd5
    } iMemAddr_e;

    // bit 0 set marks the second cycle of a fetch or push sequence
    typedef enum logic [2:0] {
        part1     = 3'd0,
        part2     = 3'd2,
        part3     = 3'd4,
        jmpFetch  = 3'd1,
        callFetch = 3'd3,
        irqEntry  = 3'd5,
        startWait = 3'd7
    } seqState_e;

    typedef struct packed {
        rfSrc_e     src;
        logic [3:0] bSel;
        logic       writeEn;
        logic       incPair;
        logic       decPair;
    } rfCtrl_t;

    typedef struct packed {
        logic       aSel;      // 1 register file, 0 status register
        aluSrcB_e   bSrc;
        aluMode_e   mode;
    } aluCtrl_t;

    typedef struct packed {
        dMemData_e  dataSel;
        dMemAddr_e  addrSel;
        logic       writeEn;
        logic       readEn;
    } memCtrl_t;

    typedef struct packed {
        srSrc_e     srSrc;
        logic       flagEnable;
        iMemAddr_e  iMemAddrSel;
        logic       iMemReadEn;
        logic       pcWriteEn;
    } flowCtrl_t;

    typedef struct packed {
        rfCtrl_t    rf;
        aluCtrl_t   alu;
        memCtrl_t   mem;
        flowCtrl_t  flow;
    } ctrlWord_t;

endpackage

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
    input  wire logic [isaPkg::instrWidth-1:0] instrWord,
    input  wire logic                          carryFlag,
    input  wire logic                          zeroFlag,
    input  wire logic                          negativeFlag,
    output isaPkg::decodedInstr_t              decoded
);
    import isaPkg::*;

    logic [4:0] opcode;
    logic       condMet;

    assign opcode = instrWord[7:3];

    // **********************************************************************
    // branch condition against the current flags
    always_comb begin
        case (condCode_e'(instrWord[15:13]))
            condCarry:   condMet = carryFlag;
            condNoCarry: condMet = ~carryFlag;
            condZero:    condMet = zeroFlag;
            condNotZero: condMet = ~zeroFlag;
            condNeg:     condMet = negativeFlag;
            condNotNeg:  condMet = ~negativeFlag;
            default:     condMet = 1'b1;   // condAlways, condAlwaysAlt
        endcase
    end

    // **********************************************************************
    // instruction class
    always_comb begin
        decoded.opClass   = opNop;
        decoded.dstIdx    = instrWord[15:12];
        decoded.srcIdx    = instrWord[11:8];
        decoded.mask      = instrWord[11:8];
        decoded.aluMode   = instrWord[6:3];
        decoded.condMet   = condMet;
        decoded.setsFlags = 1'b0;
        if (instrWord[0] && (instrWord[3:1] < 3'd7)) begin
            decoded.opClass   = opAluImm;
            decoded.aluMode   = {1'b0, instrWord[3:1]};
            decoded.setsFlags = (instrWord[3:1] != 3'd0);   // load immediate keeps flags
        end else if (instrWord[2:0] == 3'b000) begin
            case (opcode) inside
                [5'd1:5'd12]: begin
                    decoded.opClass   = opAluReg;
                    decoded.setsFlags = 1'b1;
                end
                5'd22:   decoded.opClass = opJmp;
                5'd23:   decoded.opClass = opCall;
                5'd24:   decoded.opClass = opRet;
                5'd25:   decoded.opClass = opPush;
                5'd26:   decoded.opClass = opPop;
                5'd27:   decoded.opClass = opSetSr;
                5'd28:   decoded.opClass = opClrSr;
                5'd29:   decoded.opClass = opHalt;
                default: decoded.opClass = opNop;   // includes retired pair and I/O ops
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/controlSequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlSequencer #(
    parameter int startDelay = 40
) (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire isaPkg::decodedInstr_t  decoded,
    input  wire logic                   interruptEnable,
    input  wire logic                   anyPending,
    output ctrlPkg::ctrlWord_t          ctrl,
    output logic                        irqTake
);
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int cntWidth = $clog2(startDelay + 2);
    localparam logic [3:0] spLow = 4'd14;   // stack pointer low register

    seqState_e           state;
    seqState_e           nextState;
    logic [cntWidth-1:0] delayCnt;
    logic                delayDone;

    // **********************************************************************
    // state register and start-up delay
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= startWait;
            delayCnt <= '0;
        end else begin
            state <= nextState;
            if (state == startWait) begin
                delayCnt <= delayCnt + 1'b1;
            end else begin
                delayCnt <= '0;
            end
        end
    end

    assign delayDone = (delayCnt == cntWidth'(startDelay));

    // **********************************************************************
    // control word
    always_comb begin
        ctrl.rf.src           = aluOut;
        ctrl.rf.bSel          = decoded.dstIdx;
        ctrl.rf.writeEn       = 1'b0;
        ctrl.rf.incPair       = 1'b0;
        ctrl.rf.decPair       = 1'b0;
        ctrl.alu.aSel         = 1'b1;
        ctrl.alu.bSrc         = regB;
        ctrl.alu.mode         = passB;
        ctrl.mem.dataSel      = dataAluOut;
        ctrl.mem.addrSel      = regPair;
        ctrl.mem.writeEn      = 1'b0;
        ctrl.mem.readEn       = 1'b0;
        ctrl.flow.srSrc       = aluFlags;
        ctrl.flow.flagEnable  = 1'b0;
        ctrl.flow.iMemAddrSel = pcOut;
        ctrl.flow.iMemReadEn  = 1'b1;
        ctrl.flow.pcWriteEn   = 1'b1;
        irqTake               = 1'b0;
        nextState             = part1;

        case (state)
            startWait: begin
                ctrl.flow.srSrc      = disableIrq;
                ctrl.flow.flagEnable = 1'b1;
                ctrl.flow.pcWriteEn  = delayDone;
                nextState            = delayDone ? part1 : startWait;
            end
            irqEntry: begin   // push high byte, jump to handler
                ctrl.rf.bSel          = spLow;
                ctrl.rf.decPair       = 1'b1;
                ctrl.mem.dataSel      = pcHi;
                ctrl.mem.writeEn      = 1'b1;
                ctrl.flow.srSrc       = disableIrq;
                ctrl.flow.flagEnable  = 1'b1;
                ctrl.flow.iMemAddrSel = irqVector;
                irqTake               = 1'b1;
            end
            jmpFetch: begin
                ctrl.alu.aSel         = 1'b0;
                ctrl.alu.mode         = passA;
                ctrl.flow.iMemAddrSel = iMemOut;   // target word
            end
            callFetch: begin
                ctrl.rf.bSel          = spLow;
                ctrl.rf.decPair       = 1'b1;
                ctrl.mem.dataSel      = pcNextHi;
                ctrl.mem.writeEn      = 1'b1;
                ctrl.flow.iMemAddrSel = iMemOut;
            end
            part2, part3: begin   // second and third return cycles
                ctrl.rf.bSel          = spLow;
                ctrl.rf.incPair       = (state == part2);
                ctrl.mem.addrSel      = regPairPlusOne;
                ctrl.mem.readEn       = 1'b1;
                ctrl.flow.iMemAddrSel = returnAddr;
                ctrl.flow.iMemReadEn  = (state == part3);
                ctrl.flow.pcWriteEn   = (state == part3);
                nextState             = (state == part2) ? part3 : part1;
            end
            default: begin
                if (interruptEnable && anyPending) begin
                    ctrl.rf.bSel          = spLow;
                    ctrl.rf.decPair       = 1'b1;
                    ctrl.mem.dataSel      = pcLo;
                    ctrl.mem.writeEn      = 1'b1;
                    ctrl.flow.srSrc       = disableIrq;
                    ctrl.flow.flagEnable  = 1'b1;
                    ctrl.flow.iMemAddrSel = irqVector;
                    ctrl.flow.iMemReadEn  = 1'b0;
                    ctrl.flow.pcWriteEn   = 1'b0;
                    nextState             = irqEntry;
                end else begin
                    case (decoded.opClass)
                        opAluImm: begin
                            ctrl.rf.writeEn      = 1'b1;
                            ctrl.alu.bSrc        = imm8;
                            ctrl.alu.mode        = aluMode_e'(decoded.aluMode);
                            ctrl.flow.flagEnable = decoded.setsFlags;
                        end
                        opAluReg: begin
                            ctrl.rf.bSel         = decoded.srcIdx;
                            ctrl.rf.writeEn      = 1'b1;
                            ctrl.alu.mode        = aluMode_e'(decoded.aluMode);
                            ctrl.flow.flagEnable = decoded.setsFlags;
                        end
                        opJmp: begin
                            ctrl.alu.aSel = 1'b0;
                            ctrl.alu.mode = passA;
                            if (decoded.condMet) begin
                                nextState = jmpFetch;   // read target next
                            end else begin
                                ctrl.flow.iMemAddrSel = pcPlusOne;   // skip target word
                            end
                        end
                        opCall: begin
                            ctrl.rf.bSel     = spLow;
                            ctrl.mem.dataSel = pcNextLo;
                            if (decoded.condMet) begin
                                ctrl.rf.decPair     = 1'b1;
                                ctrl.mem.writeEn    = 1'b1;
                                ctrl.flow.pcWriteEn = 1'b0;
                                nextState           = callFetch;
                            end else begin
                                ctrl.flow.iMemAddrSel = pcPlusOne;
                            end
                        end
                        opRet: begin
                            ctrl.rf.bSel     = spLow;
                            ctrl.mem.addrSel = regPairPlusOne;
                            ctrl.mem.readEn  = 1'b1;
                            if (decoded.condMet) begin
                                ctrl.rf.incPair       = 1'b1;
                                ctrl.flow.iMemAddrSel = returnAddr;
                                ctrl.flow.iMemReadEn  = 1'b0;
                                ctrl.flow.pcWriteEn   = 1'b0;
                                nextState             = part2;
                            end
                        end
                        opPush: begin   // status register onto the stack
                            ctrl.rf.bSel     = spLow;
                            ctrl.rf.decPair  = 1'b1;
                            ctrl.alu.aSel    = 1'b0;
                            ctrl.alu.mode    = passA;
                            ctrl.mem.writeEn = 1'b1;
                        end
                        opPop: begin
                            ctrl.rf.bSel         = spLow;
                            ctrl.rf.incPair      = 1'b1;
                            ctrl.alu.aSel        = 1'b0;
                            ctrl.alu.mode        = passA;
                            ctrl.mem.readEn      = 1'b1;
                            ctrl.flow.srSrc      = srMemOut;
                            ctrl.flow.flagEnable = 1'b1;
                        end
                        opSetSr, opClrSr: begin
                            ctrl.rf.bSel         = decoded.mask;
                            ctrl.alu.aSel        = 1'b0;
                            ctrl.alu.bSrc        = mask4;
                            ctrl.alu.mode        = (decoded.opClass == opSetSr) ? orOp : andOp;
                            ctrl.flow.srSrc      = srAluOut;
                            ctrl.flow.flagEnable = 1'b1;
                        end
                        opHalt: begin   // hold the current word
                            ctrl.flow.iMemReadEn = 1'b0;
                            ctrl.flow.pcWriteEn  = 1'b0;
                        end
                        default: ;   // no-op
                    endcase
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/irqLine.sv ====
`timescale 1ns/10ps
`default_nettype none

module irqLine (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic req,
    input  wire logic take,
    output logic      pending,
    output logic      ack
);
    typedef enum logic [1:0] {
        idle,
        waiting,   // request seen, not yet serviced
        acking     // ack held until req drops
    } lineState_e;

    lineState_e state;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= idle;
        end else begin
            case (state)
                idle:    if (req) state <= waiting;   // ack is low here
                waiting: if (take) state <= acking;
                acking:  if (!req) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    assign pending = (state == waiting);
    assign ack     = (state == acking);

endmodule

`default_nettype wire

// ==== verilog/irqArbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module irqArbiter #(
    parameter int irqVectorBase = 20,
    parameter int irqVectorStep = 10
) (
    input  wire logic [3:0]  pending,
    input  wire logic        irqTake,
    output logic      [3:0]  take,
    output logic             anyPending,
    output logic      [15:0] irqVector
);
    logic [3:0] grant;

    // line 0 wins, so scan downward and let the lowest index overwrite
    always_comb begin
        grant     = '0;
        irqVector = '0;   // nothing pending
        for (int i = 3; i >= 0; i--) begin
            if (pending[i]) begin
                grant     = '0;
                grant[i]  = 1'b1;
                irqVector = 16'(irqVectorBase + i * irqVectorStep);
            end
        end
    end

    assign take       = grant & {4{irqTake}};
    assign anyPending = |pending;

endmodule

`default_nettype wire

// ==== verilog/cpuControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpuControl #(
    parameter int startDelay    = 40,
    parameter int irqVectorBase = 20,
    parameter int irqVectorStep = 10
) (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire logic [isaPkg::instrWidth-1:0] instrWord,
    input  wire logic                          carryFlag,
    input  wire logic                          zeroFlag,
    input  wire logic                          negativeFlag,
    input  wire logic                          interruptEnable,
    input  wire logic [3:0]                    irqReq,
    output logic      [3:0]                    irqAck,
    output logic      [15:0]                   irqVector,
    output ctrlPkg::ctrlWord_t                 ctrl
);
    import isaPkg::*;

    decodedInstr_t decoded;
    logic [3:0]    pending;
    logic [3:0]    take;
    logic          anyPending;
    logic          irqTake;

    instrDecoder uDecoder (
        .instrWord    (instrWord),
        .carryFlag    (carryFlag),
        .zeroFlag     (zeroFlag),
        .negativeFlag (negativeFlag),
        .decoded      (decoded)
    );

    controlSequencer #(.startDelay(startDelay)) uSequencer (
        .clk             (clk),
        .rstN            (rstN),
        .decoded         (decoded),
        .interruptEnable (interruptEnable),
        .anyPending      (anyPending),
        .ctrl            (ctrl),
        .irqTake         (irqTake)
    );

    // **********************************************************************
    // interrupt sources
    for (genvar i = 0; i < 4; i++) begin : gLine
        irqLine uLine (
            .clk     (clk),
            .rstN    (rstN),
            .req     (irqReq[i]),
            .take    (take[i]),
            .pending (pending[i]),
            .ack     (irqAck[i])
        );
    end

    irqArbiter #(
        .irqVectorBase (irqVectorBase),
        .irqVectorStep (irqVectorStep)
    ) uArbiter (
        .pending    (pending),
        .irqTake    (irqTake),
        .take       (take),
        .anyPending (anyPending),
        .irqVector  (irqVector)
    );

endmodule

`default_nettype wire

// ==== verif/cpuControlTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpuControlTb;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int clkPeriod    = 4;
    localparam int resetCycles  = 10;
    localparam int startDelayTb = 8;
    localparam int numRandom    = 16;
    localparam int seed         = 44481;
    // worst case per test, plus slack for the interrupt sequences
    localparam int testCycles   = resetCycles + startDelayTb + 2 + numRandom * 12 + 40;
    localparam int watchdogNs   = (testCycles + 100) * clkPeriod;

    localparam logic [15:0] nopWord = 16'h0000;

    logic                  clk;
    logic                  rstN;
    logic [instrWidth-1:0] instrWord;
    logic                  carryFlag;
    logic                  zeroFlag;
    logic                  negativeFlag;
    logic                  interruptEnable;
    logic [3:0]            irqReq;
    logic [3:0]            irqAck;
    logic [15:0]           vectorOut;
    ctrlWord_t             ctrl;

    cpuControl #(.startDelay(startDelayTb)) DUT (
        .clk             (clk),
        .rstN            (rstN),
        .instrWord       (instrWord),
        .carryFlag       (carryFlag),
        .zeroFlag        (zeroFlag),
        .negativeFlag    (negativeFlag),
        .interruptEnable (interruptEnable),
        .irqReq          (irqReq),
        .irqAck          (irqAck),
        .irqVector       (vectorOut),
        .ctrl            (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogNs);
        $display("Timeout: tests still running after %0d ns", watchdogNs);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    // **********************************************************************
    // helpers
    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // flags are {carry, zero, negative}
    function automatic logic condHolds(input logic [2:0] cond, input logic [2:0] f);
        case (cond)
            3'd1:    return f[2];
            3'd2:    return ~f[2];
            3'd3:    return f[1];
            3'd4:    return ~f[1];
            3'd5:    return f[0];
            3'd6:    return ~f[0];
            default: return 1'b1;   // 0 and 7
        endcase
    endfunction

    task automatic drive(input logic [15:0] w, input logic [2:0] f);
        @(negedge clk);
        instrWord                             = w;
        {carryFlag, zeroFlag, negativeFlag}   = f;
        #1;   // let the combinational outputs settle
    endtask

    task automatic driveIrq(input logic [3:0] req, input logic en);
        @(negedge clk);
        instrWord       = nopWord;
        irqReq          = req;
        interruptEnable = en;
        #1;
    endtask

    // checks a plain part1 cycle of whatever word is applied
    task automatic expectPart1();
        compareValue("iMemAddrSel", ctrl.flow.iMemAddrSel, pcOut);
        compareValue("pcWriteEn", ctrl.flow.pcWriteEn, 1'b1);
        compareValue("memWriteEn", ctrl.mem.writeEn, 1'b0);
    endtask

    task automatic expectEntry(input logic [3:0] req, input logic [15:0] vec,
                               input logic [3:0] ack);
        driveIrq(req, 1'b1);   // push low byte
        compareValue("memDataSel", ctrl.mem.dataSel, pcLo);
        compareValue("memWriteEn", ctrl.mem.writeEn, 1'b1);
        compareValue("pcWriteEn", ctrl.flow.pcWriteEn, 1'b0);
        compareValue("iMemAddrSel", ctrl.flow.iMemAddrSel, ctrlPkg::irqVector);
        compareValue("irqVector", vectorOut, vec);
        compareValue("irqAck", irqAck, ack);
        driveIrq(req, 1'b1);   // push high byte, load vector
        compareValue("memDataSel", ctrl.mem.dataSel, pcHi);
        compareValue("memWriteEn", ctrl.mem.writeEn, 1'b1);
        compareValue("pcWriteEn", ctrl.flow.pcWriteEn, 1'b1);
        compareValue("iMemAddrSel", ctrl.flow.iMemAddrSel, ctrlPkg::irqVector);
        compareValue("irqVector", vectorOut, vec);
        compareValue("irqAck", irqAck, ack);
    endtask

    // **********************************************************************
    // directed tests
    task automatic resetSequence();
        repeat (resetCycles) begin
            @(negedge clk);
            #1;
            compareValue("pcWriteEn", ctrl.flow.pcWriteEn, 1'b0);
            compareValue("irqAck", irqAck, 4'b0000);
        end
        @(negedge clk);
        rstN = 1'b1;
        #1;
        for (int k = 0; k <= startDelayTb; k++) begin
            if (k > 0) begin
                @(negedge clk);
                #1;
            end
            compareValue("pcWriteEn", ctrl.flow.pcWriteEn, k == startDelayTb);
            compareValue("srSrc", ctrl.flow.srSrc, disableIrq);
            compareValue("irqAck", irqAck, 4'b0000);
        end
        drive(nopWord, 3'b000);
        expectPart1();
    endtask

    task automatic aluDecode();
        logic [2:0]  mode3;
        logic [4:0]  op;
        logic [31:0] rnd;
        logic [15:0] w;
        repeat (numRandom) begin
            mode3 = 3'($urandom_range(6, 0));
            rnd   = $urandom;
            w     = {rnd[11:0], mode3, 1'b1};
            drive(w, 3'b000);
            compareValue("aluMode", ctrl.alu.mode, {1'b0, mode3});
            compareValue("aluBSrc", ctrl.alu.bSrc, imm8);
            compareValue("rfWriteEn", ctrl.rf.writeEn, 1'b1);
            compareValue("rfSrc", ctrl.rf.src, aluOut);
            compareValue("flagEnable", ctrl.flow.flagEnable, mode3 != 3'd0);
            compareValue("pcWriteEn", ctrl.flow.pcWriteEn, 1'b1);
            op = 5'($urandom_range(12, 1));
            w  = {rnd[23:16], op, 3'b000};
            drive(w, 3'b000);
            compareValue("aluMode", ctrl.alu.mode, op[3:0]);
            compareValue("aluBSrc", ctrl.alu.bSrc, regB);
            compareValue("rfBSel", ctrl.rf.bSel, w[11:8]);
            compareValue("rfWriteEn", ctrl.rf.writeEn, 1'b1);
            compareValue("rfSrc", ctrl.rf.src, aluOut);
            compareValue("flagEnable", ctrl.flow.flagEnable, 1'b1);
            compareValue("pcWriteEn", ctrl.flow.pcWriteEn, 1'b1);
        end
        drive({8'h5a, 5'd30, 3'b000}, 3'b000);   // retired opcode runs as no-op
        expectPart1();
        compareValue("rfWriteEn", ctrl.rf.writeEn, 1'b0);
        compareValue("flagEnable", ctrl.flow.flagEnable, 1'b0);
    endtask

    task automatic condBranches();
        logic [2:0]  f;
        logic [2:0]  cond;
        logic [31:0] rnd;
        logic        met;
        repeat (numRandom) begin
            // jump
            rnd  = $urandom;
            f    = rnd[2:0];
            cond = rnd[5:3];
            met  = condHolds(cond, f);
            drive({cond, rnd[12:8], 5'd22, 3'b000}, f);
            compareValue("pcWriteEn", ctrl.flow.pcWriteEn, 1'b1);
            if (met) begin
                compareValue("iMemAddrSel", ctrl.flow.iMemAddrSel, pcOut);
                drive(nopWord, f);
                compareValue("iMemAddrSel", ctrl.flow.iMemAddrSel, iMemOut);
                compareValue("pcWriteEn", ctrl.flow.pcWriteEn, 1'b1);
            end else begin
                compareValue("iMemAddrSel", ctrl.flow.iMemAddrSel, pcPlusOne);
            end
            drive(nopWord, f);
            expectPart1();

            // call
            rnd  = $urandom;
            f    = rnd[2:0];
            cond = rnd[5:3];
            met  = condHolds(cond, f);
            drive({cond, rnd[12:8], 5'd23, 3'b000}, f);
            if (met) begin
                compareValue("pcWriteEn", ctrl.flow.pcWriteEn, 1'b0);
                compareValue("rfDecPair", ctrl.rf.decPair, 1'b1);
                compareValue("memWriteEn", ctrl.mem.writeEn, 1'b1);
                compareValue("memDataSel", ctrl.mem.dataSel, pcNextLo);
                drive(nopWord, f);
                compareValue("memWriteEn", ctrl.mem.writeEn, 1'b1);
                compareValue("memDataSel", ctrl.mem.dataSel, pcNextHi);
                compareValue("iMemAddrSel", ctrl.flow.iMemAddrSel, iMemOut);
            end else begin
                compareValue("iMemAddrSel", ctrl.flow.iMemAddrSel, pcPlusOne);
                compareValue("pcWriteEn", ctrl.flow.pcWriteEn, 1'b1);
                compareValue("memWriteEn", ctrl.mem.writeEn, 1'b0);
            end
            drive(nopWord, f);
            expectPart1();

            // return
            rnd  = $urandom;
            f    = rnd[2:0];
            cond = rnd[5:3];
            met  = condHolds(cond, f);
            drive({cond, rnd[12:8], 5'd24, 3'b000}, f);
            if (met) begin
                for (int p = 1; p <= 3; p++) begin
                    if (p > 1) begin
                        drive(nopWord, f);
                    end
                    compareValue("pcWriteEn", ctrl.flow.pcWriteEn, p == 3);
                    compareValue("rfIncPair", ctrl.rf.incPair, p != 3);
                end
            end else begin
                compareValue("iMemAddrSel", ctrl.flow.iMemAddrSel, pcOut);
                compareValue("pcWriteEn", ctrl.flow.pcWriteEn, 1'b1);
                compareValue("rfIncPair", ctrl.rf.incPair, 1'b0);
            end
            drive(nopWord, f);
            expectPart1();
        end
    endtask

    task automatic stackAndStatus();
        logic [31:0] rnd;
        rnd = $urandom;
        drive({rnd[7:0], 5'd25, 3'b000}, 3'b000);   // push
        compareValue("rfBSel", ctrl.rf.bSel, 4'd14);
        compareValue("rfDecPair", ctrl.rf.decPair, 1'b1);
        compareValue("memWriteEn", ctrl.mem.writeEn, 1'b1);
        compareValue("pcWriteEn", ctrl.flow.pcWriteEn, 1'b1);
        drive({rnd[15:8], 5'd26, 3'b000}, 3'b000);   // pop
        compareValue("rfBSel", ctrl.rf.bSel, 4'd14);
        compareValue("rfIncPair", ctrl.rf.incPair, 1'b1);
        compareValue("memReadEn", ctrl.mem.readEn, 1'b1);
        compareValue("srSrc", ctrl.flow.srSrc, srMemOut);
        compareValue("flagEnable", ctrl.flow.flagEnable, 1'b1);
        for (int s = 0; s < 2; s++) begin
            drive({rnd[23:16], (s == 0) ? 5'd27 : 5'd28, 3'b000}, 3'b000);
            compareValue("aluMode", ctrl.alu.mode, (s == 0) ? orOp : andOp);
            compareValue("aluBSrc", ctrl.alu.bSrc, mask4);
            compareValue("srSrc", ctrl.flow.srSrc, srAluOut);
            compareValue("flagEnable", ctrl.flow.flagEnable, 1'b1);
        end
        repeat (3) begin   // halt holds the word
            drive({rnd[31:24], 5'd29, 3'b000}, 3'b000);
            compareValue("pcWriteEn", ctrl.flow.pcWriteEn, 1'b0);
            compareValue("iMemReadEn", ctrl.flow.iMemReadEn, 1'b0);
        end
        drive(nopWord, 3'b000);
        expectPart1();
    endtask

    task automatic irqPriority();
        driveIrq(4'b1010, 1'b1);
        expectPart1();
        compareValue("irqAck", irqAck, 4'b0000);
        expectEntry(4'b1010, 16'd30, 4'b0000);
        expectEntry(4'b1010, 16'd50, 4'b0010);   // line 1 acks while req held
        driveIrq(4'b1000, 1'b1);
        expectPart1();
        compareValue("irqAck", irqAck, 4'b1010);
        driveIrq(4'b0000, 1'b1);
        expectPart1();
        compareValue("irqAck", irqAck, 4'b1000);
        driveIrq(4'b0000, 1'b1);
        compareValue("irqAck", irqAck, 4'b0000);
        compareValue("irqVector", vectorOut, 16'd0);   // nothing pending
    endtask

    task automatic irqMaskAndHold();
        repeat (4) begin
            driveIrq(4'b0001, 1'b0);
            expectPart1();
            compareValue("irqAck", irqAck, 4'b0000);
        end
        compareValue("irqVector", vectorOut, 16'd20);
        expectEntry(4'b0001, 16'd20, 4'b0000);
        repeat (4) begin   // held req, no repeat entry
            driveIrq(4'b0001, 1'b1);
            expectPart1();
            compareValue("irqAck", irqAck, 4'b0001);
        end
        driveIrq(4'b0101, 1'b1);
        expectPart1();
        expectEntry(4'b0101, 16'd40, 4'b0001);
        driveIrq(4'b0001, 1'b1);
        expectPart1();
        compareValue("irqAck", irqAck, 4'b0101);
        driveIrq(4'b0001, 1'b1);
        compareValue("irqAck", irqAck, 4'b0001);
        driveIrq(4'b0000, 1'b1);
        compareValue("irqAck", irqAck, 4'b0001);
        driveIrq(4'b0000, 1'b0);
        expectPart1();
        compareValue("irqAck", irqAck, 4'b0000);
    endtask

    // **********************************************************************
    // main sequence
    initial begin
        rstN            = 1'b0;
        instrWord       = nopWord;
        carryFlag       = 1'b0;
        zeroFlag        = 1'b0;
        negativeFlag    = 1'b0;
        interruptEnable = 1'b0;
        irqReq          = 4'b0000;
        void'($urandom(seed));
        resetSequence();
        aluDecode();
        condBranches();
        stackAndStatus();
        irqPriority();
        irqMaskAndHold();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/controlSequencer.sv
verilog/irqLine.sv
verilog/irqArbiter.sv
verilog/cpuControl.sv
verif/cpuControlTb.sv
